//--- hw/convPkg.sv
package convPkg;

  localparam int arrayNum   = 3;
  localparam int dataW      = 8;
  localparam int accW       = 20;
  localparam int shiftW     = 5;
  localparam int cmdCredits = 4;
  localparam int resCredits = 4;
  localparam int resDepth   = 8;
  localparam int bodyW      = 32;
  localparam int cfgPadW    = bodyW - (arrayNum - 1) - shiftW;
  localparam int cmdPtrW    = $clog2(cmdCredits);
  localparam int cmdCntW    = cmdPtrW + 1;
  localparam int resPtrW    = $clog2(resDepth);
  localparam int resCntW    = resPtrW + 1;
  localparam int resCreditW = $clog2(resCredits + 1);

  // A start word is a data beat that also opens a new window.
  typedef enum logic [1:0] {
    opCfg   = 2'd0,
    opData  = 2'd1,
    opStart = 2'd2
  } cmdOp_e;

  typedef struct packed {
    logic [cfgPadW-1:0]  pad;
    logic [shiftW-1:0]   shift;
    logic [arrayNum-2:0] passLeft;
  } cfgBody_t;

  typedef struct packed {
    logic [dataW-1:0]               weight;
    logic [arrayNum-1:0][dataW-1:0] data;
  } dataBody_t;

  // The opcode decides which view of the body is meaningful.
  typedef union packed {
    cfgBody_t  cfg;
    dataBody_t dat;
  } cmdBody_u;

  typedef struct packed {
    cmdOp_e   op;
    cmdBody_u body;
  } cmdWord_t;

  typedef struct packed {
    logic                           step;
    logic                           clearAcc;
    logic [dataW-1:0]               weight;
    logic [arrayNum-1:0][dataW-1:0] data;
  } beat_t;

  typedef struct packed {
    logic [arrayNum-2:0] passLeft;
    logic [shiftW-1:0]   shift;
  } arrayCfg_t;

  typedef struct packed {
    logic [arrayNum-1:0]            valid;
    logic [arrayNum-1:0][dataW-1:0] res;
  } resRow_t;

endpackage

//--- hw/procElem.sv
`timescale 1ns/1ps

module procElem import convPkg::*; (
  input  logic             iClk,
  input  logic             rstN,
  input  logic             step,
  input  logic [dataW-1:0] data,
  input  logic [dataW-1:0] weight,
  input  logic             clearAcc,
  output logic [dataW-1:0] weightOut,
  output logic             clearAccOut,
  output logic [accW-1:0]  acc
);

  logic [accW-1:0] accSum;
  logic [accW-1:0] product;

  assign product = accW'(data) * accW'(weight);

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      clearAccOut <= 1'b0;
    end else if (step) begin
      clearAccOut <= clearAcc;
    end
  end

  // The finished window sum moves to acc at the same step that the
  // accumulator restarts, so it sits there while clearAccOut is high.
  always_ff @(posedge iClk) begin
    if (step) begin
      weightOut <= weight;
      if (clearAcc) begin
        acc    <= accSum;
        accSum <= product;
      end else begin
        accSum <= accSum + product;
      end
    end
  end

endmodule

//--- hw/peArray.sv
`timescale 1ns/1ps

module peArray import convPkg::*; (
  input  logic      iClk,
  input  logic      rstN,
  input  beat_t     beat,
  input  arrayCfg_t arrayCfg,
  output resRow_t   row
);

  logic [dataW-1:0]               dataCache [arrayNum];
  logic [dataW-1:0]               dataDly   [arrayNum];
  logic [dataW-1:0]               dataNext  [arrayNum];
  logic [dataW-1:0]               weightChain [arrayNum+1];
  logic [arrayNum:0]              clearChain;
  logic [accW-1:0]                acc [arrayNum];
  logic [arrayNum-1:0]            seenClear;
  logic [arrayNum-1:0]            rowValid;
  logic [arrayNum-1:0][dataW-1:0] rowRes;

  // Each element but the last may take its right neighbour's data
  // from one step back instead of its own byte.
  always_comb begin
    for (int k = 0; k < arrayNum; k++) begin
      dataNext[k] = beat.data[k];
    end
    for (int k = 0; k < arrayNum - 1; k++) begin
      if (arrayCfg.passLeft[k]) begin
        dataNext[k] = dataDly[k+1];
      end
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      for (int k = 0; k < arrayNum; k++) begin
        dataCache[k] <= '0;
        dataDly[k]   <= '0;
      end
    end else if (beat.step) begin
      for (int k = 0; k < arrayNum; k++) begin
        dataCache[k] <= dataNext[k];
        dataDly[k]   <= dataCache[k];
      end
    end
  end

  // Weight and clear enter the chain through one register, which keeps
  // them aligned with the data caches at element 0.
  always_ff @(posedge iClk) begin
    if (beat.step) begin
      weightChain[0] <= beat.weight;
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      clearChain[0] <= 1'b0;
    end else if (beat.step) begin
      clearChain[0] <= beat.clearAcc;
    end
  end

  for (genvar i = 0; i < arrayNum; i++) begin : genElem
    procElem uElem (
      .iClk        (iClk),
      .rstN        (rstN),
      .step        (beat.step),
      .data        (dataCache[i]),
      .weight      (weightChain[i]),
      .clearAcc    (clearChain[i]),
      .weightOut   (weightChain[i+1]),
      .clearAccOut (clearChain[i+1]),
      .acc         (acc[i])
    );
  end

  // The first clear an element sees closes no window, so it reports nothing.
  always_ff @(posedge iClk) begin
    if (!rstN) begin
      seenClear <= '0;
      rowValid  <= '0;
    end else if (beat.step) begin
      seenClear <= seenClear | clearChain[arrayNum:1];
      rowValid  <= seenClear & clearChain[arrayNum:1];
    end else begin
      rowValid  <= '0;
    end
  end

  always_ff @(posedge iClk) begin
    if (beat.step) begin
      for (int k = 0; k < arrayNum; k++) begin
        rowRes[k] <= dataW'(acc[k] >> arrayCfg.shift);
      end
    end
  end

  assign row.valid = rowValid;
  assign row.res   = rowRes;

endmodule

//--- hw/cmdDecode.sv
`timescale 1ns/1ps

module cmdDecode import convPkg::*; (
  input  logic      iClk,
  input  logic      rstN,
  input  logic      cmdValid,
  input  cmdWord_t  cmd,
  input  logic      resRoom,
  output logic      cmdCreditReturn,
  output beat_t     beat,
  output arrayCfg_t arrayCfg
);

  cmdWord_t           cmdMem [cmdCredits];
  logic [cmdPtrW-1:0] wrPtr;
  logic [cmdPtrW-1:0] rdPtr;
  logic [cmdCntW-1:0] fill;
  logic               push;
  logic               pop;
  cmdWord_t           head;
  cfgBody_t           headCfg;
  dataBody_t          headData;

  assign push = cmdValid && (fill < cmdCntW'(cmdCredits));
  assign pop  = (fill != '0) && resRoom;

  assign head     = cmdMem[rdPtr];
  assign headCfg  = head.body.cfg;
  assign headData = head.body.dat;

  always_ff @(posedge iClk) begin
    if (push) begin
      cmdMem[wrPtr] <= cmd;
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end else begin
      wrPtr <= wrPtr + cmdPtrW'(push);
      rdPtr <= rdPtr + cmdPtrW'(pop);
      fill  <= fill + cmdCntW'(push) - cmdCntW'(pop);
    end
  end

  // Every pop frees a queue slot, so it hands a credit back at once.
  assign cmdCreditReturn = pop;

  assign beat.step     = pop && (head.op == opData || head.op == opStart);
  assign beat.clearAcc = pop && (head.op == opStart);
  assign beat.weight   = headData.weight;
  assign beat.data     = headData.data;

  // Configuration is registered, so it applies from the next beat on.
  always_ff @(posedge iClk) begin
    if (!rstN) begin
      arrayCfg <= '0;
    end else if (pop && head.op == opCfg) begin
      arrayCfg.passLeft <= headCfg.passLeft;
      arrayCfg.shift    <= headCfg.shift;
    end
  end

endmodule

//--- hw/resultPack.sv
`timescale 1ns/1ps

module resultPack import convPkg::*; (
  input  logic    iClk,
  input  logic    rstN,
  input  resRow_t row,
  input  logic    resCreditReturn,
  output logic    resRoom,
  output logic    resValid,
  output resRow_t res
);

  resRow_t               rowMem [resDepth];
  logic [resPtrW-1:0]    wrPtr;
  logic [resPtrW-1:0]    rdPtr;
  logic [resCntW-1:0]    fill;
  logic [resCreditW-1:0] credits;
  logic                  push;
  logic                  pop;

  // Rows without any finished element carry nothing worth sending.
  assign push = |row.valid;
  assign pop  = (fill != '0) && (credits != '0);

  // Up to two rows can still be on their way from the array after the
  // decoder sees this drop, so it keeps arrayNum slots in reserve.
  assign resRoom = fill <= resCntW'(resDepth - arrayNum);

  always_ff @(posedge iClk) begin
    if (push) begin
      rowMem[wrPtr] <= row;
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end else begin
      wrPtr <= wrPtr + resPtrW'(push);
      rdPtr <= rdPtr + resPtrW'(pop);
      fill  <= fill + resCntW'(push) - resCntW'(pop);
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      credits <= resCreditW'(resCredits);
    end else begin
      credits <= credits - resCreditW'(pop) + resCreditW'(resCreditReturn);
    end
  end

  always_ff @(posedge iClk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else begin
      resValid <= pop;
    end
  end

  always_ff @(posedge iClk) begin
    if (pop) begin
      res <= rowMem[rdPtr];
    end
  end

endmodule

//--- hw/convRowTop.sv
`timescale 1ns/1ps

module convRowTop import convPkg::*; (
  input  logic     iClk,
  input  logic     rstN,
  input  logic     cmdValid,
  input  cmdWord_t cmd,
  output logic     cmdCreditReturn,
  output logic     resValid,
  output resRow_t  res,
  input  logic     resCreditReturn
);

  beat_t     beat;
  arrayCfg_t arrayCfg;
  resRow_t   row;
  logic      resRoom;

  cmdDecode uDecode (
    .iClk            (iClk),
    .rstN            (rstN),
    .cmdValid        (cmdValid),
    .cmd             (cmd),
    .resRoom         (resRoom),
    .cmdCreditReturn (cmdCreditReturn),
    .beat            (beat),
    .arrayCfg        (arrayCfg)
  );

  peArray uArray (
    .iClk     (iClk),
    .rstN     (rstN),
    .beat     (beat),
    .arrayCfg (arrayCfg),
    .row      (row)
  );

  resultPack uPack (
    .iClk            (iClk),
    .rstN            (rstN),
    .row             (row),
    .resCreditReturn (resCreditReturn),
    .resRoom         (resRoom),
    .resValid        (resValid),
    .res             (res)
  );

endmodule

//--- bench/convRowChecker.sv
`timescale 1ns/1ps

module convRowChecker import convPkg::*; (
  input logic iClk,
  input logic rstN,
  input logic cmdValid,
  input logic cmdCreditReturn,
  input logic resValid,
  input logic resCreditReturn
);

  logic started = 1'b0;
  int   outCredits;
  int   cmdsIn;
  int   cmdsBack;

  // The first edge samples values from before reset took hold.
  always @(posedge iClk) begin
    started <= 1'b1;
  end

  always @(posedge iClk) begin
    if (!rstN) begin
      outCredits <= resCredits;
      cmdsIn     <= 0;
      cmdsBack   <= 0;
    end else begin
      outCredits <= outCredits - int'(resValid) + int'(resCreditReturn);
      cmdsIn     <= cmdsIn + int'(cmdValid);
      cmdsBack   <= cmdsBack + int'(cmdCreditReturn);
    end
  end

  assert property (@(posedge iClk) (started && !rstN) |-> !resValid)
    else $error("resValid asserted during reset");

  assert property (@(posedge iClk) (started && !rstN) |-> !cmdCreditReturn)
    else $error("cmdCreditReturn asserted during reset");

  assert property (@(posedge iClk) disable iff (!rstN) resValid |-> (outCredits > 0))
    else $error("resValid with no output credit outstanding");

  assert property (@(posedge iClk) disable iff (!rstN) cmdCreditReturn |-> (cmdsBack < cmdsIn))
    else $error("cmdCreditReturn beyond the commands received");

endmodule

bind convRowTop convRowChecker uChecker (
  .iClk            (iClk),
  .rstN            (rstN),
  .cmdValid        (cmdValid),
  .cmdCreditReturn (cmdCreditReturn),
  .resValid        (resValid),
  .resCreditReturn (resCreditReturn)
);

//--- bench/convRowMonitor.sv
`timescale 1ns/1ps

module convRowMonitor import convPkg::*; (
  input  logic     iClk,
  input  logic     rstN,
  input  logic     cmdValid,
  input  cmdWord_t cmd,
  input  logic     resValid,
  input  resRow_t  res,
  output int       errors,
  output int       pending
);

  logic [dataW-1:0]    cache   [arrayNum];
  logic [dataW-1:0]    dly     [arrayNum];
  logic [dataW-1:0]    weights [arrayNum];
  logic [arrayNum:0]   clears;
  logic [accW-1:0]     sum     [arrayNum];
  logic [accW-1:0]     done    [arrayNum];
  logic [arrayNum-1:0] seen;
  arrayCfg_t           cfg;
  resRow_t             expQ [$];

  // Bytes of elements that closed no window carry no meaning.
  function automatic resRow_t maskRow(input resRow_t r);
    resRow_t m;
    m = r;
    for (int k = 0; k < arrayNum; k++) begin
      if (!r.valid[k]) begin
        m.res[k] = '0;
      end
    end
    return m;
  endfunction

  // One array step. Element k sees data one step late and weight and clear
  // k+1 steps late; a closed window is reported one step after it closes.
  task automatic stepModel(input dataBody_t b, input logic clr);
    resRow_t          r;
    logic [dataW-1:0] nxt [arrayNum];
    r.valid = seen & clears[arrayNum:1];
    seen    = seen | clears[arrayNum:1];
    for (int k = 0; k < arrayNum; k++) begin
      r.res[k] = dataW'(done[k] / (32'd1 << cfg.shift));
      if (clears[k]) begin
        done[k] = sum[k];
        sum[k]  = accW'(cache[k]) * accW'(weights[k]);
      end else begin
        sum[k]  = sum[k] + accW'(cache[k]) * accW'(weights[k]);
      end
    end
    for (int k = arrayNum - 1; k > 0; k--) begin
      weights[k] = weights[k-1];
    end
    weights[0] = b.weight;
    clears     = {clears[arrayNum-1:0], clr};
    for (int k = 0; k < arrayNum; k++) begin
      nxt[k] = b.data[k];
    end
    for (int k = 0; k < arrayNum - 1; k++) begin
      if (cfg.passLeft[k]) begin
        nxt[k] = dly[k+1];
      end
    end
    for (int k = 0; k < arrayNum; k++) begin
      dly[k]   = cache[k];
      cache[k] = nxt[k];
    end
    if (|r.valid) begin
      expQ.push_back(r);
    end
  endtask

  always @(posedge iClk) begin
    resRow_t want;
    if (!rstN) begin
      for (int k = 0; k < arrayNum; k++) begin
        cache[k] = '0;
        dly[k]   = '0;
      end
      clears = '0;
      seen   = '0;
      cfg    = '0;
      errors = 0;
      expQ.delete();
    end else begin
      if (resValid && expQ.size() == 0) begin
        $display("Row on res at %0t when no row was expected: %h", $time, res);
        errors++;
      end else if (resValid) begin
        want = expQ.pop_front();
        if (maskRow(res) !== maskRow(want)) begin
          $display("FAILED %0t res expected %h got %h", $time, maskRow(want), maskRow(res));
          errors++;
        end
      end
      if (cmdValid && cmd.op == opCfg) begin
        cfg.passLeft = cmd.body.cfg.passLeft;
        cfg.shift    = cmd.body.cfg.shift;
      end else if (cmdValid) begin
        stepModel(cmd.body.dat, cmd.op == opStart);
      end
    end
    pending = expQ.size();
  end

endmodule

//--- bench/convRowTb.sv
`timescale 1ns/1ps

module convRowTb import convPkg::*; ();

  localparam int randCmds  = 300;
  localparam int totalCmds = randCmds + arrayNum + 3;

  logic        iClk;
  logic        rstN;
  logic        cmdValid;
  cmdWord_t    cmd;
  logic        cmdCreditReturn;
  logic        resValid;
  resRow_t     res;
  logic        resCreditReturn;
  logic [31:0] rngState;
  int          sent;
  int          creditsBack;
  int          rowsIn;
  int          rowsAck;
  int          tbErrors;
  int          monErrors;
  int          pending;
  int          waitCycles;

  convRowTop dut (.*);

  convRowMonitor uMonitor (.errors(monErrors), .*);

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Mostly data words with starts and configuration words mixed in. The tail
  // is one start and arrayNum+2 zero beats, which flush the last window.
  function automatic cmdWord_t makeCmd(input int idx);
    cmdWord_t    c;
    logic [31:0] r;
    r      = nextRand();
    c.body = nextRand();
    c.op   = opData;
    if (idx == 0 || idx == randCmds || (idx < randCmds && r[2:0] == 3'd1)) begin
      c.op = opStart;
    end else if (idx > randCmds) begin
      c.body = '0;
    end else if (r[2:0] == 3'd2) begin
      c.op                = opCfg;
      c.body              = '0;
      c.body.cfg.passLeft = r[8] ? r[arrayNum+2:4] : '0;
      c.body.cfg.shift    = r[9] ? shiftW'(r[14:11]) : '0;
    end
    return c;
  endfunction

  // One cycle of stimulus. Output credits trickle back slowly for a while.
  task automatic tick(input logic sendOk);
    logic [31:0] r;
    logic        slow;
    @(negedge iClk);
    r               = nextRand();
    slow            = (sent >= 100) && (sent < 200);
    resCreditReturn = (rowsIn > rowsAck) && (!slow || r[2:0] == 3'd0);
    rowsAck        += int'(resCreditReturn);
    cmdValid        = sendOk && (sent < totalCmds) && ((sent - creditsBack) < cmdCredits)
                      && (r[5:3] != 3'd0);
    if (cmdValid) begin
      cmd = makeCmd(sent);
      sent++;
    end
  endtask

  always @(posedge iClk) begin
    if (!rstN) begin
      creditsBack <= 0;
      rowsIn      <= 0;
    end else begin
      creditsBack <= creditsBack + int'(cmdCreditReturn);
      rowsIn      <= rowsIn + int'(resValid);
    end
  end

  initial begin
    iClk = 1'b0;
    forever #4 iClk = ~iClk;
  end

  initial begin
    rngState        = 32'd61;
    rstN            = 1'b0;
    cmdValid        = 1'b0;
    cmd             = '0;
    resCreditReturn = 1'b0;
    sent            = 0;
    rowsAck         = 0;
    tbErrors        = 0;
    repeat (16) @(posedge iClk);
    @(negedge iClk);
    rstN       = 1'b1;
    waitCycles = 0;
    while (sent < totalCmds && waitCycles < 20000) begin
      tick(1'b1);
      waitCycles++;
    end
    waitCycles = 0;
    while ((creditsBack < sent || pending > 0) && waitCycles < 3000) begin
      tick(1'b0);
      waitCycles++;
    end
    if (sent < totalCmds) begin
      $display("Timeout: only %0d of %0d commands were sent", sent, totalCmds);
      tbErrors++;
    end
    if (creditsBack != sent) begin
      $display("cmdCreditReturn pulsed %0d times for %0d commands sent", creditsBack, sent);
      tbErrors++;
    end
    if (pending > 0) begin
      $display("Timeout: %0d expected rows never appeared on res", pending);
      tbErrors++;
    end
    // A stray row after the last expected one is caught by the monitor.
    repeat (20) tick(1'b0);
    $display("Errors: monitor %0d, testbench %0d", monErrors, tbErrors);
    if (monErrors == 0 && tbErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
hw/convPkg.sv
hw/procElem.sv
hw/peArray.sv
hw/cmdDecode.sv
hw/resultPack.sv
hw/convRowTop.sv
bench/convRowChecker.sv
bench/convRowMonitor.sv
bench/convRowTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= convRowTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
